//--- build.f
+incdir+rtl
rtl/vend_pkg.sv
rtl/button_conditioner.sv
rtl/input_decode.sv
rtl/credit_engine.sv
rtl/display_driver.sv
rtl/vending_top.sv
tb/vending_tb.sv

//--- tb/vending_tb.sv
`include "vend_params.svh"

module vending_tb;

    import vend_pkg::*;

    localparam int DEPTH       = 4;
    localparam int REFRESH     = 3;
    localparam int MAX_EXTRA   = 7;
    // generous bound on stimulus steps below
    localparam int STEPS       = 80;
    localparam int STEP_CYCLES = DEPTH + (1 << REFRESH) + MAX_EXTRA + 2;
    // a digit goes dark for at most one refresh period plus the register stages
    localparam int LIT_LIMIT   = (1 << REFRESH) + 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        btn_5;
    logic        btn_10;
    logic        btn_50;
    logic        btn_cancel;
    logic        scan_valid;
    scan_code_t  scan_code;
    vend_evt_t   vend;
    change_evt_t change;
    logic [7:0]  seg;
    logic [3:0]  an;
    logic [3:0]  afford;

    // shadow model of the credit and the expected events
    money_t      model_credit;
    // credit one cycle back, what the registered display shows
    money_t      shown_credit;
    logic        exp_vend;
    drink_id_t   exp_drink;
    logic        exp_change;
    money_t      exp_amount;
    logic        break_seen;
    // {cancel, coin_50, coin_10, coin_5}, pulses allowed on cmd now
    logic [3:0]  armed;
    logic [3:0]  btn_cmd;
    int          seed_init;
    int          action;
    // samples since each digit was last lit
    int          dark_units;
    int          dark_tens;
    scan_code_t  keys [6] = '{`KEY_A, `KEY_S, `KEY_D, `KEY_F, 8'h15, `KEY_BREAK_PREFIX};

    vending_top #(.DEBOUNCE_DEPTH(DEPTH), .REFRESH_BITS(REFRESH)) vending_top_i (
        .clk        (clk),
        .rst        (rst),
        .btn_5      (btn_5),
        .btn_10     (btn_10),
        .btn_50     (btn_50),
        .btn_cancel (btn_cancel),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .vend       (vend),
        .change     (change),
        .seg        (seg),
        .an         (an),
        .afford     (afford)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        shown_credit <= model_credit;
    end

    // counts restart whenever the digit is lit
    always @(posedge clk) begin
        if (rst || !an[0]) begin
            dark_units <= 0;
        end else begin
            dark_units <= dark_units + 1;
        end
        if (rst || !an[1]) begin
            dark_tens <= 0;
        end else begin
            dark_tens <= dark_tens + 1;
        end
    end

    // button side of the decoded command
    assign btn_cmd = {vending_top_i.cmd.cancel, vending_top_i.cmd.coin_50,
                      vending_top_i.cmd.coin_10, vending_top_i.cmd.coin_5};

    function automatic money_t price_of_drink(input drink_id_t d);
        case (d)
            2'd0:    return `VEND_PRICE_0;
            2'd1:    return `VEND_PRICE_1;
            2'd2:    return `VEND_PRICE_2;
            default: return `VEND_PRICE_3;
        endcase
    endfunction

    function automatic money_t coin_value(input int kind);
        case (kind)
            0:       return `VEND_COIN_5;
            1:       return `VEND_COIN_10;
            default: return `VEND_COIN_50;
        endcase
    endfunction

    function automatic money_t add_saturated(input money_t a, input money_t b);
        int sum;
        sum = int'(a) + int'(b);
        if (sum > int'(`VEND_CREDIT_MAX)) begin
            return `VEND_CREDIT_MAX;
        end
        return money_t'(sum);
    endfunction

    function automatic logic [3:0] afford_mask(input money_t c);
        return {c >= `VEND_PRICE_3, c >= `VEND_PRICE_2, c >= `VEND_PRICE_1, c >= `VEND_PRICE_0};
    endfunction

    // -1 for anything that is not a drink key
    function automatic int drink_of_key(input scan_code_t code);
        case (code)
            `KEY_A:  return 0;
            `KEY_S:  return 1;
            `KEY_D:  return 2;
            `KEY_F:  return 3;
            default: return -1;
        endcase
    endfunction

    // dp off, then g..a, low lights a segment
    function automatic logic [7:0] seg_pattern(input int d);
        case (d)
            0:       return 8'b1100_0000;
            1:       return 8'b1111_1001;
            2:       return 8'b1010_0100;
            3:       return 8'b1011_0000;
            4:       return 8'b1001_1001;
            5:       return 8'b1001_0010;
            6:       return 8'b1000_0010;
            7:       return 8'b1111_1000;
            8:       return 8'b1000_0000;
            default: return 8'b1001_0000;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string test, input int expected, input int actual);
        fail_run($sformatf("[FAIL] %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    // inputs always move 1 unit after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_button(input int kind, input logic level);
        case (kind)
            0:       btn_5 = level;
            1:       btn_10 = level;
            2:       btn_50 = level;
            default: btn_cancel = level;
        endcase
    endtask

    // kind 0..2 coins, 3 cancel; hold on for extra cycles after the pulse
    task automatic press_button(input int kind, input int extra);
        int   waited;
        logic hit;
        waited = 0;
        hit = 1'b0;
        armed = 4'b0001 << kind;
        drive_button(kind, 1'b1);
        while (!hit) begin
            step_cycle();
            hit = btn_cmd[kind];
            waited++;
            if (!hit && waited > DEPTH + 3) begin
                fail_run("a held button never produced a command pulse");
            end
        end
        // credit and change register one edge after cmd
        step_cycle();
        armed = 4'b0000;
        if (kind == 3) begin
            exp_change = (model_credit != '0);
            exp_amount = model_credit;
            model_credit = '0;
        end else begin
            model_credit = add_saturated(model_credit, coin_value(kind));
        end
        step_cycle();
        exp_change = 1'b0;
        repeat (extra) step_cycle();
        drive_button(kind, 1'b0);
        // let the debounce window drain
        repeat (DEPTH) step_cycle();
    endtask

    // released before the debounce window fills
    task automatic tap_button(input int kind, input int cycles);
        drive_button(kind, 1'b1);
        repeat (cycles) step_cycle();
        drive_button(kind, 1'b0);
        repeat (DEPTH + 4) step_cycle();
    endtask

    task automatic send_scan(input scan_code_t code);
        int   key;
        logic will_vend;
        key = drink_of_key(code);
        will_vend = 1'b0;
        // byte after F0 is the released key, swallowed
        if (break_seen) begin
            break_seen = 1'b0;
        end else if (code == `KEY_BREAK_PREFIX) begin
            break_seen = 1'b1;
        end else if (key >= 0) begin
            will_vend = (model_credit >= price_of_drink(drink_id_t'(key)));
        end
        scan_valid = 1'b1;
        scan_code = code;
        step_cycle();
        scan_valid = 1'b0;
        step_cycle();
        // vend registered on the edge just passed
        if (will_vend) begin
            exp_vend = 1'b1;
            exp_drink = drink_id_t'(key);
            model_credit = model_credit - price_of_drink(exp_drink);
        end
        step_cycle();
        exp_vend = 1'b0;
        step_cycle();
    endtask

    a_credit: assert property (@(posedge clk) disable iff (rst)
        vending_top_i.credit == model_credit)
        else fail_value("credit", $sampled(model_credit), $sampled(vending_top_i.credit));

    a_afford: assert property (@(posedge clk) disable iff (rst)
        afford == afford_mask(model_credit))
        else fail_value("afford", afford_mask($sampled(model_credit)), $sampled(afford));

    a_vend: assert property (@(posedge clk) disable iff (rst)
        vend.valid == exp_vend)
        else fail_value("vend pulse", $sampled(exp_vend), $sampled(vend.valid));

    a_vend_drink: assert property (@(posedge clk) disable iff (rst)
        vend.valid |-> vend.drink == exp_drink)
        else fail_value("vend drink", $sampled(exp_drink), $sampled(vend.drink));

    a_change: assert property (@(posedge clk) disable iff (rst)
        change.valid == exp_change)
        else fail_value("change pulse", $sampled(exp_change), $sampled(change.valid));

    a_change_amount: assert property (@(posedge clk) disable iff (rst)
        change.valid |-> change.amount == exp_amount)
        else fail_value("change amount", $sampled(exp_amount), $sampled(change.amount));

    a_seg_units: assert property (@(posedge clk) disable iff (rst)
        !an[0] |-> seg == seg_pattern(shown_credit % 10))
        else fail_value("units digit", seg_pattern($sampled(shown_credit) % 10), $sampled(seg));

    a_seg_tens: assert property (@(posedge clk) disable iff (rst)
        !an[1] |-> seg == seg_pattern(shown_credit / 10))
        else fail_value("tens digit", seg_pattern($sampled(shown_credit) / 10), $sampled(seg));

    // digits 2 and 3 are not fitted
    a_an_unused: assert property (@(posedge clk) disable iff (rst)
        an[3:2] == 2'b11)
        else fail_value("unused anodes", 3, $sampled(an[3:2]));

    a_an_single: assert property (@(posedge clk) disable iff (rst)
        an[1:0] != 2'b00)
        else fail_run("both display digits were driven at once");

    // each digit comes back within one refresh period
    a_units_lit: assert property (@(posedge clk) disable iff (rst)
        dark_units <= LIT_LIMIT)
        else fail_run("the units digit stayed dark past one refresh period");

    a_tens_lit: assert property (@(posedge clk) disable iff (rst)
        dark_tens <= LIT_LIMIT)
        else fail_run("the tens digit stayed dark past one refresh period");

    // one coin per long hold, none for a short tap
    a_button_cmd: assert property (@(posedge clk) disable iff (rst)
        (btn_cmd & ~armed) == 4'b0000)
        else fail_value("button command", $sampled(armed), $sampled(btn_cmd));

    initial begin
        #(STEPS * STEP_CYCLES * 4 * 2);
        fail_run("the run timed out before the stimulus finished");
    end

    initial begin
        seed_init = $urandom(32'h1d2a8b87);
        rst = 1'b1;
        btn_5 = 1'b0;
        btn_10 = 1'b0;
        btn_50 = 1'b0;
        btn_cancel = 1'b0;
        scan_valid = 1'b0;
        scan_code = '0;
        model_credit = '0;
        exp_vend = 1'b0;
        exp_drink = '0;
        exp_change = 1'b0;
        exp_amount = '0;
        break_seen = 1'b0;
        armed = 4'b0000;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2 << REFRESH) step_cycle();
        // random coins, then two 50s to reach the ceiling
        repeat (12) press_button($urandom_range(2), $urandom_range(MAX_EXTRA));
        press_button(2, 0);
        press_button(2, 3);
        repeat (2 << REFRESH) step_cycle();
        // refund, then an empty cancel
        press_button(3, 0);
        press_button(3, 2);
        press_button(1, 0);
        press_button(1, 1);
        send_scan(`KEY_A);
        send_scan(`KEY_F);
        press_button(2, 0);
        press_button(1, 0);
        send_scan(`KEY_F);
        press_button(2, 2);
        send_scan(`KEY_D);
        send_scan(`KEY_S);
        send_scan(`KEY_A);
        // release sequence and unknown codes
        press_button(2, 0);
        send_scan(`KEY_BREAK_PREFIX);
        send_scan(`KEY_A);
        send_scan(8'h15);
        send_scan(`KEY_A);
        press_button(3, 0);
        tap_button(1, DEPTH - 1);
        tap_button(0, $urandom_range(1, DEPTH - 1));
        repeat (24) begin
            action = $urandom_range(5);
            if (action < 3) begin
                press_button(action, $urandom_range(MAX_EXTRA));
            end else if (action == 3) begin
                press_button(3, 0);
            end else begin
                send_scan(keys[$urandom_range(5)]);
            end
        end
        repeat (2 << REFRESH) step_cycle();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/vending_top.sv
module vending_top #(
    parameter int DEBOUNCE_DEPTH = 4,
    parameter int REFRESH_BITS   = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_5,
    input  logic                  btn_10,
    input  logic                  btn_50,
    input  logic                  btn_cancel,
    input  logic                  scan_valid,
    input  vend_pkg::scan_code_t  scan_code,
    output vend_pkg::vend_evt_t   vend,
    output vend_pkg::change_evt_t change,
    output logic [7:0]            seg,
    output logic [3:0]            an,
    output logic [3:0]            afford
);

    import vend_pkg::*;

    // decode to execute
    user_cmd_t cmd;
    // execute to result
    money_t    credit;

    input_decode #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) input_decode_i (
        .clk        (clk),
        .rst        (rst),
        .btn_5      (btn_5),
        .btn_10     (btn_10),
        .btn_50     (btn_50),
        .btn_cancel (btn_cancel),
        .scan_valid (scan_valid),
        .scan_code  (scan_code),
        .cmd        (cmd)
    );

    credit_engine credit_engine_i (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .credit (credit),
        .vend   (vend),
        .change (change)
    );

    display_driver #(.REFRESH_BITS(REFRESH_BITS)) display_driver_i (
        .clk    (clk),
        .rst    (rst),
        .credit (credit),
        .seg    (seg),
        .an     (an),
        .afford (afford)
    );

endmodule

//--- rtl/display_driver.sv
`include "vend_params.svh"

module display_driver #(
    parameter int REFRESH_BITS = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  vend_pkg::money_t credit,
    output logic [7:0]       seg,
    output logic [3:0]       an,
    output logic [3:0]       afford
);

    import vend_pkg::*;

    // free-running refresh counter, top bit picks the digit
    logic [REFRESH_BITS-1:0] refresh_cnt;
    logic                    refresh_tick;
    logic                    digit_sel;
    // set at the first tick, digits stay dark before
    logic                    display_on;
    // decimal split of the credit
    bcd_t                    tens;
    bcd_t                    units;
    money_t                  tens_val;
    bcd_t                    digit;

    // common anode pattern, {dp, g, f, e, d, c, b, a}, low lights
    function automatic logic [7:0] seg_encode(input bcd_t d);
        case (d)
            4'd0:    seg_encode = 8'hC0;
            4'd1:    seg_encode = 8'hF9;
            4'd2:    seg_encode = 8'hA4;
            4'd3:    seg_encode = 8'hB0;
            4'd4:    seg_encode = 8'h99;
            4'd5:    seg_encode = 8'h92;
            4'd6:    seg_encode = 8'h82;
            4'd7:    seg_encode = 8'hF8;
            4'd8:    seg_encode = 8'h80;
            4'd9:    seg_encode = 8'h90;
            default: seg_encode = 8'hFF;
        endcase
    endfunction

    // tens by comparing against 10, 20 .. 90, largest match wins
    always_comb begin
        tens = '0;
        for (int i = 1; i <= 9; i++) begin
            if (credit >= money_t'(10 * i)) begin
                tens = bcd_t'(i);
            end
        end
        tens_val = money_t'(tens) * 7'd10;
        units    = bcd_t'(credit - tens_val);
    end

    assign refresh_tick = &refresh_cnt;
    assign digit_sel    = refresh_cnt[REFRESH_BITS-1];
    // 1 shows tens on an[1], 0 shows units on an[0]
    assign digit        = digit_sel ? tens : units;

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            display_on  <= 1'b0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (refresh_tick) begin
                display_on <= 1'b1;
            end
        end
    end

    // registered segment and anode drive
    always_ff @(posedge clk) begin
        if (rst) begin
            seg <= 8'hFF;
            an  <= 4'b1111;
        end else if (display_on || refresh_tick) begin
            seg <= seg_encode(digit);
            an  <= digit_sel ? 4'b1101 : 4'b1110;
        end
    end

    // led i lights when drink i is affordable
    assign afford[0] = (credit >= `VEND_PRICE_0);
    assign afford[1] = (credit >= `VEND_PRICE_1);
    assign afford[2] = (credit >= `VEND_PRICE_2);
    assign afford[3] = (credit >= `VEND_PRICE_3);

    // never two digits driven at once
    a_an_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(~an)
    );

endmodule

//--- rtl/credit_engine.sv
`include "vend_params.svh"

module credit_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::user_cmd_t   cmd,
    output vend_pkg::money_t      credit,
    output vend_pkg::vend_evt_t   vend,
    output vend_pkg::change_evt_t change
);

    import vend_pkg::*;

    // price of the requested drink
    money_t     price;
    // coin value of this cycle, 0 when none
    money_t     coin_val;
    logic       coin_any;
    // one spare bit, 99 + 50 still fits
    logic [7:0] coin_sum;
    money_t     credit_sat;

    // drink id to price
    function automatic money_t price_of(input drink_id_t d);
        case (d)
            2'd0:    price_of = `VEND_PRICE_0;
            2'd1:    price_of = `VEND_PRICE_1;
            2'd2:    price_of = `VEND_PRICE_2;
            default: price_of = `VEND_PRICE_3;
        endcase
    endfunction

    assign price = price_of(cmd.drink);

    // cmd is one-hot, so order here is cosmetic
    always_comb begin
        coin_val = '0;
        if (cmd.coin_50) begin
            coin_val = `VEND_COIN_50;
        end else if (cmd.coin_10) begin
            coin_val = `VEND_COIN_10;
        end else if (cmd.coin_5) begin
            coin_val = `VEND_COIN_5;
        end
    end

    assign coin_any = cmd.coin_5 | cmd.coin_10 | cmd.coin_50;

    // saturating add
    always_comb begin
        coin_sum = {1'b0, credit} + {1'b0, coin_val};
        if (coin_sum > {1'b0, `VEND_CREDIT_MAX}) begin
            credit_sat = `VEND_CREDIT_MAX;
        end else begin
            credit_sat = coin_sum[6:0];
        end
    end

    // credit and event registers, one cycle after cmd
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= '0;
            vend   <= '0;
            change <= '0;
        end else begin
            // events are single-cycle pulses
            vend.valid   <= 1'b0;
            change.valid <= 1'b0;
            if (cmd.cancel) begin
                // empty cancel is silent
                if (credit != '0) begin
                    change.valid  <= 1'b1;
                    change.amount <= credit;
                    credit        <= '0;
                end
            end else if (cmd.select) begin
                // not enough money, nothing happens
                if (credit >= price) begin
                    vend.valid <= 1'b1;
                    vend.drink <= cmd.drink;
                    credit     <= credit - price;
                end
            end else if (coin_any) begin
                credit <= credit_sat;
            end
        end
    end

    // credit stays within two digits
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credit <= `VEND_CREDIT_MAX
    );

    // a vend was paid for by the credit before it
    a_vend_paid: assert property (
        @(posedge clk) disable iff (rst)
        vend.valid |-> ($past(credit) >= price_of(vend.drink))
    );

    // vend and refund are mutually exclusive
    a_vend_change_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(vend.valid && change.valid)
    );

endmodule

//--- rtl/input_decode.sv
`include "vend_params.svh"

module input_decode #(
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 btn_5,
    input  logic                 btn_10,
    input  logic                 btn_50,
    input  logic                 btn_cancel,
    input  logic                 scan_valid,
    input  vend_pkg::scan_code_t scan_code,
    output vend_pkg::user_cmd_t  cmd
);

    import vend_pkg::*;

    // conditioned button pulses
    logic        pulse_5;
    logic        pulse_10;
    logic        pulse_50;
    logic        pulse_cancel;
    // scan parser
    scan_state_e scan_state;
    logic        key_known;
    drink_id_t   key_drink;
    logic        key_hit;
    user_cmd_t   cmd_next;

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) cond_5_i (
        .clk   (clk),
        .rst   (rst),
        .level (btn_5),
        .pulse (pulse_5)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) cond_10_i (
        .clk   (clk),
        .rst   (rst),
        .level (btn_10),
        .pulse (pulse_10)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) cond_50_i (
        .clk   (clk),
        .rst   (rst),
        .level (btn_50),
        .pulse (pulse_50)
    );

    button_conditioner #(.DEBOUNCE_DEPTH(DEBOUNCE_DEPTH)) cond_cancel_i (
        .clk   (clk),
        .rst   (rst),
        .level (btn_cancel),
        .pulse (pulse_cancel)
    );

    // break prefix arms SCAN_BREAK, the next byte is swallowed
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_state <= SCAN_IDLE;
        end else if (scan_valid) begin
            case (scan_state)
                SCAN_IDLE: begin
                    if (scan_code == `KEY_BREAK_PREFIX) begin
                        scan_state <= SCAN_BREAK;
                    end
                end
                default: scan_state <= SCAN_IDLE;
            endcase
        end
    end

    // make code to drink index
    always_comb begin
        key_known = 1'b1;
        key_drink = 2'd0;
        case (scan_code)
            `KEY_A:  key_drink = 2'd0;
            `KEY_S:  key_drink = 2'd1;
            `KEY_D:  key_drink = 2'd2;
            `KEY_F:  key_drink = 2'd3;
            default: key_known = 1'b0;
        endcase
    end

    // only fresh presses count, never the byte after F0
    assign key_hit = scan_valid && (scan_state == SCAN_IDLE) && key_known;

    // fixed priority, losers this cycle are dropped
    always_comb begin
        cmd_next = '0;
        if (pulse_cancel) begin
            cmd_next.cancel = 1'b1;
        end else if (key_hit) begin
            cmd_next.select = 1'b1;
            cmd_next.drink  = key_drink;
        end else if (pulse_50) begin
            cmd_next.coin_50 = 1'b1;
        end else if (pulse_10) begin
            cmd_next.coin_10 = 1'b1;
        end else if (pulse_5) begin
            cmd_next.coin_5 = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd <= cmd_next;
        end
    end

    // credit engine relies on a single request per cycle
    a_cmd_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({cmd.coin_5, cmd.coin_10, cmd.coin_50, cmd.cancel, cmd.select})
    );

endmodule

//--- rtl/button_conditioner.sv
module button_conditioner #(
    parameter int DEBOUNCE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic level,
    output logic pulse
);

    // sample history, newest in bit 0
    logic [DEBOUNCE_DEPTH-1:0] sample_sr;
    // debounced level and its previous value
    logic                      stable;
    logic                      stable_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_sr <= '0;
            stable_q  <= 1'b0;
        end else begin
            sample_sr <= {sample_sr[DEBOUNCE_DEPTH-2:0], level};
            stable_q  <= stable;
        end
    end

    // high only once every sample in the window is high
    assign stable = &sample_sr;

    // rising edge of the stable level
    // a new pulse needs stable to drop first
    assign pulse = stable & ~stable_q;

    // one press, one pulse
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        pulse |=> !pulse
    );

endmodule

//--- rtl/vend_pkg.sv
package vend_pkg;

    // credit, price and change amounts, 0..99 fits in 7 bits
    typedef logic [6:0] money_t;
    // one of four drinks
    typedef logic [1:0] drink_id_t;
    // raw keyboard byte
    typedef logic [7:0] scan_code_t;
    // single decimal digit
    typedef logic [3:0] bcd_t;

    // decoded user request, at most one pulse high per cycle
    typedef struct packed {
        logic      coin_5;
        logic      coin_10;
        logic      coin_50;
        logic      cancel;
        logic      select;
        drink_id_t drink;
    } user_cmd_t;

    // drink dispensed this cycle
    typedef struct packed {
        logic      valid;
        drink_id_t drink;
    } vend_evt_t;

    // change returned this cycle
    typedef struct packed {
        logic   valid;
        money_t amount;
    } change_evt_t;

    // break prefix tracking for the scan decoder
    typedef enum logic {SCAN_IDLE, SCAN_BREAK} scan_state_e;

endpackage

//--- rtl/vend_params.svh
`ifndef VEND_PARAMS_SVH
`define VEND_PARAMS_SVH

// drink prices, indexed by drink id
`define VEND_PRICE_0 7'd20
`define VEND_PRICE_1 7'd25
`define VEND_PRICE_2 7'd30
`define VEND_PRICE_3 7'd60

// credit saturates here, two display digits
`define VEND_CREDIT_MAX 7'd99

// coin values per button
`define VEND_COIN_5 7'd5
`define VEND_COIN_10 7'd10
`define VEND_COIN_50 7'd50

// ps/2 set 2 make codes for a, s, d, f
`define KEY_A 8'h1C
`define KEY_S 8'h1B
`define KEY_D 8'h23
`define KEY_F 8'h2B
// release prefix, next byte is the released key
`define KEY_BREAK_PREFIX 8'hF0

`endif
